/* rtl/osf_pkg.sv */
`default_nettype none

package osf_pkg;

	////////////////////
	// datapath widths
	////////////////////

	localparam int W_IN_DEF  = 18;	// input sample width
	localparam int W_OUT_DEF = 18;	// output sample width
	localparam int W_ORT_DEF = 4;	// log_ovr field, windows up to 2^15
	localparam int W_DELAY   = 16;	// inter-window skip count

	// gain is signed fixed point, 256 is unity
	localparam int W_GAIN    = 16;
	localparam int GAIN_FRAC = 8;	// fractional bits of gain

	////////////////////
	// front panel map
	////////////////////

	localparam int W_FP_ADDR = 2;

	typedef enum logic [W_FP_ADDR-1:0] {
		FP_LOG_OVR     = 2'd0,	// log2 of oversample ratio
		FP_CYCLE_DELAY = 2'd1,	// valid strobes skipped between windows
		FP_GAIN        = 2'd2,	// signed gain word
		FP_ACTIVATE    = 2'd3	// bit 0 is channel enable
	} fp_addr_t;

endpackage

`default_nettype wire

/* rtl/fp_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module fp_ctrl #(
	parameter int W_ORT = 4	// width of log2 oversample ratio
) (
	input  logic                               clk_in,
	input  logic                               reset_in,

	// front panel write port
	input  logic                               fp_wr_in,	// single cycle strobe
	input  osf_pkg::fp_addr_t                  fp_addr_in,
	input  logic [15:0]                        fp_data_in,

	// update qualification
	input  logic                               update_en_in,	// level
	input  logic                               update_in,	// pulse

	// active settings -> datapath
	output logic [W_ORT-1:0]                   log_ovr,
	output logic [osf_pkg::W_DELAY-1:0]        cycle_delay,
	output logic signed [osf_pkg::W_GAIN-1:0]  gain,
	output logic                               active,
	output logic                               apply	// one cycle after update
);

	import osf_pkg::*;

	////////////////////
	// shadow bank
	////////////////////

	// host writes land here, datapath never sees them directly
	logic [W_ORT-1:0]          sh_log_ovr;
	logic [W_DELAY-1:0]        sh_cycle_delay;
	logic signed [W_GAIN-1:0]  sh_gain;
	logic                      sh_active;

	logic                      do_update;	// qualified update this cycle

	assign do_update = update_in & update_en_in;	// ignored when not enabled

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			sh_log_ovr     <= '0;
			sh_cycle_delay <= '0;
			sh_gain        <= '0;
			sh_active      <= 1'b0;
		end else if (fp_wr_in) begin
			case (fp_addr_in)
				FP_LOG_OVR: begin
					sh_log_ovr <= fp_data_in[W_ORT-1:0];	// upper bits dropped
				end
				FP_CYCLE_DELAY: begin
					sh_cycle_delay <= fp_data_in[W_DELAY-1:0];
				end
				FP_GAIN: begin
					sh_gain <= signed'(fp_data_in[W_GAIN-1:0]);
				end
				FP_ACTIVATE: begin
					sh_active <= fp_data_in[0];	// enable level
				end
				default: begin
					sh_active <= sh_active;
				end
			endcase
		end
	end

	////////////////////
	// active bank
	////////////////////

	// copy on a qualified update
	// values and apply show up together on the next cycle
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			log_ovr     <= '0;
			cycle_delay <= '0;
			gain        <= '0;
			active      <= 1'b0;
		end else if (do_update) begin
			log_ovr     <= sh_log_ovr;
			cycle_delay <= sh_cycle_delay;
			gain        <= sh_gain;
			active      <= sh_active;
		end
	end

	// apply strobe, restarts the filter window
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			apply <= 1'b0;
		end else begin
			apply <= do_update;	// high for exactly one cycle per update
		end
	end

endmodule

`default_nettype wire

/* rtl/oversample_filter.sv */
`timescale 1ns/1ns
`default_nettype none

module oversample_filter #(
	parameter int W_IN  = 18,	// sample width
	parameter int W_ORT = 4	// log_ovr width
) (
	input  logic                         clk_in,
	input  logic                         reset_in,

	// samples from upstream
	input  logic signed [W_IN-1:0]       data_in,
	input  logic                         data_valid_in,	// may come on any cycle

	// settings from fp_ctrl
	input  logic [W_ORT-1:0]             log_ovr,
	input  logic [osf_pkg::W_DELAY-1:0]  cycle_delay,
	input  logic                         active,
	input  logic                         apply,

	// window mean out
	output logic signed [W_IN-1:0]       mean,
	output logic                         mean_valid
);

	import osf_pkg::*;

	// sum of 2^(2^W_ORT - 1) samples needs this many bits
	localparam int W_ACC = W_IN + 2**W_ORT - 1;
	// counter covers both window count and delay count
	localparam int W_CNT = (2**W_ORT > W_DELAY) ? 2**W_ORT : W_DELAY;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SAMPLE,
		ST_SEND,
		ST_DELAY
	} state_t;

	state_t                    state;
	state_t                    state_nxt;

	logic [W_CNT-1:0]          count;	// valid strobes seen in this state
	logic [W_CNT-1:0]          cnt_inc;
	logic [W_CNT-1:0]          win_last;	// 2^log_ovr - 1
	logic signed [W_ACC-1:0]   sum;
	logic signed [W_ACC-1:0]   sum_shift;
	logic                      window_done;
	logic                      delay_done;
	logic                      restart;	// clear count

	////////////////////
	// decode
	////////////////////

	assign cnt_inc  = count + 1'b1;
	assign win_last = (W_CNT'(1) << log_ovr) - 1'b1;

	// strobe that completes the window
	assign window_done = data_valid_in && (state == ST_SAMPLE) && (count == win_last);
	// last strobe to discard
	assign delay_done  = data_valid_in && (state == ST_DELAY) && (cnt_inc == W_CNT'(cycle_delay));

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE:   state_nxt = ST_SAMPLE;	// only reached with active high
			ST_SAMPLE: if (window_done) state_nxt = ST_SEND;
			ST_SEND:   state_nxt = (cycle_delay == '0) ? ST_SAMPLE : ST_DELAY;
			ST_DELAY:  if (delay_done) state_nxt = ST_SAMPLE;
			default:   state_nxt = ST_IDLE;
		endcase
		if (apply) begin
			state_nxt = ST_SAMPLE;	// fresh window on new settings
		end
		if (!active) begin
			state_nxt = ST_IDLE;	// deactivated channel parks here
		end
	end

	assign restart = (state_nxt != state) || apply || !active;

	////////////////////
	// state and count
	////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state <= ST_IDLE;
			count <= '0;
		end else begin
			state <= state_nxt;
			if (restart) begin
				count <= '0;
			end else if (data_valid_in && (state == ST_SAMPLE || state == ST_DELAY)) begin
				count <= cnt_inc;	// send cycle strobes fall through
			end
		end
	end

	// accumulator, held through SEND then cleared
	always_ff @(posedge clk_in) begin
		if (apply || !active || state != ST_SAMPLE) begin
			sum <= '0;
		end else if (data_valid_in) begin
			sum <= sum + {{(W_ACC-W_IN){data_in[W_IN-1]}}, data_in};	// sign extend
		end
	end

	////////////////////
	// output
	////////////////////

	assign sum_shift  = sum >>> log_ovr;	// floor divide by 2^log_ovr
	assign mean       = sum_shift[W_IN-1:0];	// mean fits in input width
	assign mean_valid = (state == ST_SEND);

endmodule

`default_nettype wire

/* rtl/output_scaler.sv */
`timescale 1ns/1ns
`default_nettype none

module output_scaler #(
	parameter int W_IN  = 18,	// mean width
	parameter int W_OUT = 18	// output width
) (
	input  logic                               clk_in,
	input  logic                               reset_in,

	// mean from filter
	input  logic signed [W_IN-1:0]             mean,
	input  logic                               mean_valid,

	// gain from fp_ctrl
	input  logic signed [osf_pkg::W_GAIN-1:0]  gain,

	// scaled result
	output logic signed [W_OUT-1:0]            data_out,
	output logic                               data_valid_out,
	output logic                               sat_out	// valid with data_valid_out only
);

	import osf_pkg::*;

	localparam int W_PROD = W_IN + W_GAIN;	// full signed product

	// clamp limits, sign extended to product width
	localparam logic signed [W_PROD-1:0] OUT_MAX = {{(W_PROD-W_OUT+1){1'b0}}, {(W_OUT-1){1'b1}}};
	localparam logic signed [W_PROD-1:0] OUT_MIN = {{(W_PROD-W_OUT+1){1'b1}}, {(W_OUT-1){1'b0}}};

	logic signed [W_PROD-1:0]  prod;	// stage 1
	logic                      prod_valid;
	logic signed [W_PROD-1:0]  prod_shift;

	////////////////////
	// stage 1 multiply
	////////////////////

	always_ff @(posedge clk_in) begin
		prod <= mean * gain;	// no reset on payload
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			prod_valid <= 1'b0;
		end else begin
			prod_valid <= mean_valid;
		end
	end

	////////////////////
	// stage 2 saturate
	////////////////////

	assign prod_shift = prod >>> GAIN_FRAC;	// drop fraction, floor

	always_ff @(posedge clk_in) begin
		if (prod_shift > OUT_MAX) begin
			data_out <= OUT_MAX[W_OUT-1:0];	// clip high
			sat_out  <= 1'b1;
		end else if (prod_shift < OUT_MIN) begin
			data_out <= OUT_MIN[W_OUT-1:0];	// clip low
			sat_out  <= 1'b1;
		end else begin
			data_out <= prod_shift[W_OUT-1:0];
			sat_out  <= 1'b0;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			data_valid_out <= 1'b0;
		end else begin
			data_valid_out <= prod_valid;	// two cycles after mean_valid
		end
	end

endmodule

`default_nettype wire

/* rtl/osf_channel_top.sv */
`timescale 1ns/1ns
`default_nettype none

module osf_channel_top #(
	parameter int W_IN  = osf_pkg::W_IN_DEF,
	parameter int W_OUT = osf_pkg::W_OUT_DEF,
	parameter int W_ORT = osf_pkg::W_ORT_DEF
) (
	input  logic                      clk_in,
	input  logic                      reset_in,

	// sample stream
	input  logic signed [W_IN-1:0]    data_in,
	input  logic                      data_valid_in,

	// front panel
	input  logic                      fp_wr_in,
	input  osf_pkg::fp_addr_t         fp_addr_in,
	input  logic [15:0]               fp_data_in,
	input  logic                      update_en_in,
	input  logic                      update_in,

	// scaled output
	output logic signed [W_OUT-1:0]   data_out,
	output logic                      data_valid_out,
	output logic                      sat_out
);

	import osf_pkg::*;

	////////////////////
	// internal nets
	////////////////////

	logic [W_ORT-1:0]          log_ovr;
	logic [W_DELAY-1:0]        cycle_delay;
	logic signed [W_GAIN-1:0]  gain;
	logic                      active;
	logic                      apply;	// settings just changed

	logic signed [W_IN-1:0]    mean;
	logic                      mean_valid;

	// settings and activation
	fp_ctrl #(
		.W_ORT (W_ORT)
	) i_fp_ctrl (
		.clk_in       (clk_in),
		.reset_in     (reset_in),
		.fp_wr_in     (fp_wr_in),
		.fp_addr_in   (fp_addr_in),
		.fp_data_in   (fp_data_in),
		.update_en_in (update_en_in),
		.update_in    (update_in),
		.log_ovr      (log_ovr),
		.cycle_delay  (cycle_delay),
		.gain         (gain),
		.active       (active),
		.apply        (apply)
	);

	// window average
	oversample_filter #(
		.W_IN  (W_IN),
		.W_ORT (W_ORT)
	) i_oversample_filter (
		.clk_in        (clk_in),
		.reset_in      (reset_in),
		.data_in       (data_in),
		.data_valid_in (data_valid_in),
		.log_ovr       (log_ovr),
		.cycle_delay   (cycle_delay),
		.active        (active),
		.apply         (apply),
		.mean          (mean),
		.mean_valid    (mean_valid)
	);

	// gain and clamp
	output_scaler #(
		.W_IN  (W_IN),
		.W_OUT (W_OUT)
	) i_output_scaler (
		.clk_in         (clk_in),
		.reset_in       (reset_in),
		.mean           (mean),
		.mean_valid     (mean_valid),
		.gain           (gain),
		.data_out       (data_out),
		.data_valid_out (data_valid_out),
		.sat_out        (sat_out)
	);

endmodule

`default_nettype wire

/* sim/osf_channel_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module osf_channel_tb;

	import osf_pkg::*;

	localparam int OUT_MAX     = 2**(W_OUT_DEF-1) - 1;
	localparam int OUT_MIN     = -(2**(W_OUT_DEF-1));
	localparam int DRAIN_LIMIT = 40;	// cycles allowed for pending outputs
	localparam int LATENCY     = 3;	// completing strobe to data_valid_out
	localparam int SAT_NONE    = 0;
	localparam int SAT_SOME    = 1;	// row must clamp at least once
	localparam int N_ROWS      = 10;

	typedef struct {
		int log_ovr;
		int cycle_delay;
		int gain;
		int update_en;
		int act;
		int n_samples;	// valid strobes driven
		int sat_mode;
	} row_t;

	logic                        clk_in;
	logic                        reset_in;
	logic signed [W_IN_DEF-1:0]  data_in;
	logic                        data_valid_in;
	logic                        fp_wr_in;
	fp_addr_t                    fp_addr_in;
	logic [15:0]                 fp_data_in;
	logic                        update_en_in;
	logic                        update_in;
	logic signed [W_OUT_DEF-1:0] data_out;
	logic                        data_valid_out;
	logic                        sat_out;

	row_t                        rows [N_ROWS];
	logic [31:0]                 rng;
	logic signed [W_OUT_DEF-1:0] exp_data [$];	// model output queue
	logic                        exp_sat [$];
	int                          exp_due [$];	// cycle each result must appear in
	int                          cyc_num;	// clock count since reset release
	int                          sat_seen;	// clamps seen in current row

	////////////////////
	// model state
	////////////////////
	int     sh_log;	// shadow copy of host writes
	int     sh_delay;
	longint sh_gain;
	logic   sh_act;
	logic   m_active;
	logic   m_apply;	// apply cycle drops the strobe
	logic   m_send;	// send cycle drops the strobe
	logic   m_delaying;
	int     m_cnt;
	longint m_sum;
	int     m_log;
	int     m_delay;
	longint m_gain;

	osf_channel_top #(
		.W_IN  (W_IN_DEF),
		.W_OUT (W_OUT_DEF),
		.W_ORT (W_ORT_DEF)
	) i_osf_channel_top (
		.clk_in         (clk_in),
		.reset_in       (reset_in),
		.data_in        (data_in),
		.data_valid_in  (data_valid_in),
		.fp_wr_in       (fp_wr_in),
		.fp_addr_in     (fp_addr_in),
		.fp_data_in     (fp_data_in),
		.update_en_in   (update_en_in),
		.update_in      (update_in),
		.data_out       (data_out),
		.data_valid_out (data_valid_out),
		.sat_out        (sat_out)
	);

	initial clk_in = 1'b0;
	always #10 clk_in = ~clk_in;	// 20 ns period

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input logic signed [W_OUT_DEF-1:0] got,
			input logic signed [W_OUT_DEF-1:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch at %0t ns: %s got %0d expected %0d",
				$time, name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch at %0t ns: %s got %b expected %b",
				$time, name, got, exp));
		end
	endtask

	// floor mean, gain, floor shift, clamp
	task automatic push_expected(input longint sum);
		longint mean;
		longint scaled;
		mean   = sum >>> m_log;
		scaled = (mean * m_gain) >>> GAIN_FRAC;
		exp_due.push_back(cyc_num + LATENCY);
		if (scaled > OUT_MAX) begin
			exp_data.push_back(W_OUT_DEF'(OUT_MAX));
			exp_sat.push_back(1'b1);
		end else if (scaled < OUT_MIN) begin
			exp_data.push_back(W_OUT_DEF'(OUT_MIN));
			exp_sat.push_back(1'b1);
		end else begin
			exp_data.push_back(W_OUT_DEF'(scaled));
			exp_sat.push_back(1'b0);
		end
	endtask

	// one clock of the reference model on this cycle's inputs
	task automatic model_cycle();
		if (fp_wr_in) begin
			case (fp_addr_in)
				FP_LOG_OVR:     sh_log = int'(fp_data_in[W_ORT_DEF-1:0]);	// truncated field
				FP_CYCLE_DELAY: sh_delay = int'(fp_data_in);
				FP_GAIN:        sh_gain = longint'(signed'(fp_data_in));
				FP_ACTIVATE:    sh_act = fp_data_in[0];
				default:        sh_act = sh_act;
			endcase
		end
		if (update_in && update_en_in) begin
			m_log      = sh_log;
			m_delay    = sh_delay;
			m_gain     = sh_gain;
			m_active   = sh_act;
			m_apply    = 1'b1;
			m_send     = 1'b0;
			m_delaying = 1'b0;
			m_cnt      = 0;
			m_sum      = 0;
		end else if (m_apply) begin
			m_apply = 1'b0;	// fresh window starts after this
		end else if (m_active) begin
			if (m_send) begin
				m_send     = 1'b0;
				m_delaying = (m_delay != 0);
				m_cnt      = 0;
			end else if (data_valid_in && m_delaying) begin
				m_cnt++;
				if (m_cnt == m_delay) begin
					m_delaying = 1'b0;
					m_cnt      = 0;
				end
			end else if (data_valid_in) begin
				m_sum += data_in;
				m_cnt++;
				if (m_cnt == (1 << m_log)) begin	// window full
					push_expected(m_sum);
					m_sum  = 0;
					m_cnt  = 0;
					m_send = 1'b1;
				end
			end
		end
	endtask

	task automatic check_outputs();
		logic signed [W_OUT_DEF-1:0] d;
		logic                        s;
		int                          due;
		if (data_valid_out === 1'b1) begin
			if (exp_data.size() == 0) begin
				fail_run($sformatf("data_valid_out at %0t ns with no output expected", $time));
			end else begin
				d   = exp_data.pop_front();
				s   = exp_sat.pop_front();
				due = exp_due.pop_front();
				if (due != cyc_num) begin
					fail_run($sformatf("data_valid_out at %0t ns came in cycle %0d, due in cycle %0d",
						$time, cyc_num, due));
				end
				check_data("data_out", data_out, d);
				check_flag("sat_out", sat_out, s);
				if (s) sat_seen++;
			end
		end else if (exp_due.size() != 0 && exp_due[0] <= cyc_num) begin
			fail_run($sformatf("no data_valid_out at %0t ns although a result was due", $time));
		end
	endtask

	// inputs set before the call are taken at the next rising edge
	task automatic tick();
		model_cycle();
		@(negedge clk_in);
		cyc_num++;	// cycle the outputs now belong to
		check_outputs();	// outputs settled since the rising edge
		data_valid_in = 1'b0;
		data_in       = '0;
		fp_wr_in      = 1'b0;
		update_in     = 1'b0;
	endtask

	task automatic write_reg(input fp_addr_t addr, input int value);
		fp_wr_in   = 1'b1;
		fp_addr_in = addr;
		fp_data_in = 16'(value);
		tick();
	endtask

	task automatic send_samples(input int n);
		int sent;
		int cycles;
		sent   = 0;
		cycles = 0;
		while (sent < n && cycles < n * 16) begin
			rng = xorshift32(rng);
			if (rng[0]) begin	// valid on about half the cycles
				data_valid_in = 1'b1;
				data_in       = rng[W_IN_DEF:1];
				sent++;
			end
			tick();
			cycles++;
		end
		if (sent < n) fail_run("stimulus stalled before all samples were sent");
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (exp_data.size() != 0 && waited < DRAIN_LIMIT) begin
			tick();
			waited++;
		end
		if (exp_data.size() != 0) begin
			fail_run($sformatf("no data_valid_out within %0d cycles for a pending result",
				DRAIN_LIMIT));
		end else begin
			repeat (4) tick();	// stray strobes show up here
		end
	endtask

	task automatic run_row(input int idx);
		row_t r;
		r        = rows[idx];
		sat_seen = 0;
		update_en_in = (r.update_en != 0);	// level held for the whole row
		write_reg(FP_LOG_OVR, r.log_ovr);
		write_reg(FP_CYCLE_DELAY, r.cycle_delay);
		write_reg(FP_GAIN, r.gain);
		write_reg(FP_ACTIVATE, r.act);
		update_in = 1'b1;
		tick();
		tick();	// apply cycle
		send_samples(r.n_samples);
		drain();
		if (r.sat_mode == SAT_SOME && sat_seen == 0) begin
			fail_run($sformatf("row %0d never saturated although its gain should clamp", idx));
		end
	endtask

	initial begin
		// log_ovr, cycle_delay, gain, update_en, act, n_samples, sat_mode
		rows[0] = '{0, 0, 256, 1, 1, 12, SAT_NONE};
		rows[1] = '{2, 0, 256, 1, 1, 24, SAT_NONE};
		rows[2] = '{5, 0, 256, 1, 1, 70, SAT_NONE};
		rows[3] = '{2, 3, 256, 1, 1, 40, SAT_NONE};	// skip 3 between windows
		rows[4] = '{0, 0, 1024, 0, 1, 30, SAT_NONE};	// ignored update so row 3 holds
		rows[5] = '{2, 1, 1024, 1, 1, 40, SAT_SOME};
		rows[6] = '{0, 2, -640, 1, 1, 30, SAT_SOME};
		rows[7] = '{3, 0, 64, 1, 1, 43, SAT_NONE};	// ends on a partial window
		rows[8] = '{2, 0, 256, 1, 0, 16, SAT_NONE};	// channel off
		rows[9] = '{2, 0, 256, 1, 1, 18, SAT_NONE};
		rng = 32'd13;
		cyc_num = 0;
		sh_log = 0;
		sh_delay = 0;
		sh_gain = 0;
		sh_act = 1'b0;
		m_active = 1'b0;
		m_apply = 1'b0;
		m_send = 1'b0;
		m_delaying = 1'b0;
		m_cnt = 0;
		m_sum = 0;
		m_log = 0;
		m_delay = 0;
		m_gain = 0;
		reset_in = 1'b1;
		data_in = '0;
		data_valid_in = 1'b0;
		fp_wr_in = 1'b0;
		fp_addr_in = FP_LOG_OVR;
		fp_data_in = '0;
		update_en_in = 1'b0;
		update_in = 1'b0;
		repeat (10) @(posedge clk_in);
		@(negedge clk_in);
		reset_in = 1'b0;
		send_samples(20);	// no output before the first apply
		drain();
		for (int i = 0; i < N_ROWS; i++) begin
			run_row(i);
		end
		if (exp_data.size() != 0) begin
			fail_run("expected outputs left over at end of run");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* osf_channel_top.f */
rtl/osf_pkg.sv
rtl/fp_ctrl.sv
rtl/oversample_filter.sv
rtl/output_scaler.sv
rtl/osf_channel_top.sv
sim/osf_channel_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the channel testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module osf_channel_tb \
	-f osf_channel_top.f -o osf_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/osf_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "All checks passed" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
